//--- verilog/dcache_pkg.sv
package dcache_pkg;

	// geometry of the cache and of the backing store
	localparam int ADDR_W      = 12;  // byte address
	localparam int WORD_W      = 32;
	localparam int LINE_WORDS  = 4;   // also the bank count
	localparam int LINE_COUNT  = 16;
	localparam int MEM_LINES   = 256;
	localparam int MEM_LATENCY = 3;   // request pulse to ready pulse

	localparam int STRB_W        = WORD_W / 8;  // one strobe per byte
	localparam int BYTE_OFS_BITS = $clog2(STRB_W);
	localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);

	// address split: tag | index | word | byte
	localparam int OFFSET_BITS = BYTE_OFS_BITS + WORD_SEL_BITS;
	localparam int INDEX_BITS  = $clog2(LINE_COUNT);
	localparam int TAG_BITS    = ADDR_W - INDEX_BITS - OFFSET_BITS;

	localparam int LAT_CNT_W = $clog2(MEM_LATENCY + 1);  // latency counter width

	localparam logic [1:0] RESP_OKAY = 2'b00;  // the only response ever sent

	typedef logic [ADDR_W-1:0]        addr_t;
	typedef logic [WORD_W-1:0]        word_t;
	typedef logic [STRB_W-1:0]        strb_t;
	typedef logic [INDEX_BITS-1:0]    index_t;
	typedef logic [TAG_BITS-1:0]      tag_t;
	typedef logic [WORD_SEL_BITS-1:0] word_sel_t;

	// backing store line number, tag over index
	typedef logic [TAG_BITS+INDEX_BITS-1:0] line_addr_t;

	// cache controller states
	typedef enum logic [1:0] {
		IDLE,
		COMPARE,
		WRITE_BACK,
		ALLOCATE
	} ctrl_state_t;

endpackage

//--- verilog/line_bus_if.sv
`timescale 1ns/1ps

interface line_bus_if import dcache_pkg::*; ();

	// cpu side of the data array, from the controller
	index_t    index;      // line being accessed
	word_sel_t word_sel;   // which bank takes a cpu write
	logic      cpu_we;
	word_t     wmask;      // bit mask from the byte strobes
	word_t     cpu_wdata;

	// line fill, controller forwards the memory read line
	logic                    fill_we;
	word_t [LINE_WORDS-1:0]  fill_line;

	// one element per bank, async read of the indexed entry
	word_t bank_words [LINE_WORDS];

	modport ctrl (
		output index, word_sel, cpu_we, wmask, cpu_wdata, fill_we, fill_line,
		input  bank_words
	);

	modport bank (
		input  index, word_sel, cpu_we, wmask, cpu_wdata, fill_we, fill_line,
		output bank_words
	);

	modport mem (
		input bank_words  // old line on write-back
	);

endinterface

//--- verilog/axil_cpu_port.sv
`timescale 1ns/1ps

module axil_cpu_port import dcache_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       awvalid,
	output logic       awready,
	input  addr_t      awaddr,
	input  logic       wvalid,
	output logic       wready,
	input  word_t      wdata,
	input  strb_t      wstrb,
	output logic       bvalid,
	input  logic       bready,
	output logic [1:0] bresp,
	input  logic       arvalid,
	output logic       arready,
	input  addr_t      araddr,
	output logic       rvalid,
	input  logic       rready,
	output word_t      rdata,
	output logic [1:0] rresp,
	output logic       req_valid,
	output logic       req_write,
	output addr_t      req_addr,
	output word_t      req_wdata,
	output word_t      req_wmask,
	input  logic       req_done,
	input  word_t      req_rdata
);

	typedef enum logic [1:0] {
		ACCEPT,   // waiting for a transaction
		BUSY,     // request held for the controller
		RESPOND   // b or r channel pending
	} port_state_t;

	port_state_t state;
	word_t       strb_mask;
	logic        wr_go;
	logic        rd_go;
	logic        resp_taken;

	// aw and w taken together, write wins over a read
	assign awready = (state == ACCEPT) && awvalid && wvalid;
	assign wready  = awready;
	assign arready = (state == ACCEPT) && arvalid && !(awvalid && wvalid);

	assign wr_go = awvalid && awready && wvalid && wready;
	assign rd_go = arvalid && arready;

	assign req_valid  = (state == BUSY);
	assign bvalid     = (state == RESPOND) && req_write;
	assign rvalid     = (state == RESPOND) && !req_write;
	assign resp_taken = (bvalid && bready) || (rvalid && rready);
	assign bresp      = RESP_OKAY;
	assign rresp      = RESP_OKAY;

	// each strobe widened to its byte
	always_comb begin
		for (int i = 0; i < STRB_W; i++) begin
			strb_mask[8*i +: 8] = {8{wstrb[i]}};
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= ACCEPT;
			req_write <= 1'b0;
		end else begin
			unique case (state)
				ACCEPT: begin
					if (wr_go) begin
						req_write <= 1'b1;
						state     <= BUSY;
					end else if (rd_go) begin
						req_write <= 1'b0;
						state     <= BUSY;
					end
				end
				BUSY:    if (req_done) state <= RESPOND;
				RESPOND: if (resp_taken) state <= ACCEPT;  // master took it
				default: state <= ACCEPT;
			endcase
		end
	end

	// request fields and read data, held while busy or responding
	always_ff @(posedge clk) begin
		if (wr_go) begin
			req_addr  <= awaddr;
			req_wdata <= wdata;
			req_wmask <= strb_mask;
		end else if (rd_go) begin
			req_addr <= araddr;
		end
		if (state == BUSY && req_done && !req_write)
			rdata <= req_rdata;  // stable until rready
	end

endmodule

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	input  logic                   req_write,
	input  addr_t                  req_addr,
	input  word_t                  req_wdata,
	input  word_t                  req_wmask,
	output logic                   req_done,
	output word_t                  req_rdata,
	output logic                   mem_valid,
	output logic                   mem_write,
	output line_addr_t             mem_line_addr,
	input  logic                   mem_ready,
	input  word_t [LINE_WORDS-1:0] mem_rline,
	line_bus_if.ctrl               bus
);

	ctrl_state_t state;
	ctrl_state_t state_nx;

	// tag array, one entry per line
	logic line_valid [LINE_COUNT];
	logic line_dirty [LINE_COUNT];
	tag_t line_tag   [LINE_COUNT];

	tag_t      req_tag;
	index_t    req_index;
	word_sel_t req_word;
	logic      hit;
	logic      tag_we;     // new tag on a miss
	logic      dirty_set;  // write hit

	assign req_tag   = req_addr[ADDR_W-1 -: TAG_BITS];
	assign req_index = req_addr[OFFSET_BITS +: INDEX_BITS];
	assign req_word  = req_addr[BYTE_OFS_BITS +: WORD_SEL_BITS];
	assign hit       = line_valid[req_index] && (line_tag[req_index] == req_tag);

	assign bus.index     = req_index;
	assign bus.word_sel  = req_word;
	assign bus.wmask     = req_wmask;
	assign bus.cpu_wdata = req_wdata;
	assign bus.fill_line = mem_rline;   // only taken with fill_we
	assign req_rdata     = bus.bank_words[req_word];

	always_comb begin
		state_nx      = state;
		req_done      = 1'b0;
		mem_valid     = 1'b0;
		mem_write     = 1'b0;
		mem_line_addr = {req_tag, req_index};  // fetch address by default
		bus.cpu_we    = 1'b0;
		bus.fill_we   = 1'b0;
		tag_we        = 1'b0;
		dirty_set     = 1'b0;
		unique case (state)
			IDLE: if (req_valid) state_nx = COMPARE;
			COMPARE: begin
				if (hit) begin
					req_done   = 1'b1;
					bus.cpu_we = req_write;  // merged into the word on this edge
					dirty_set  = req_write;
					state_nx   = IDLE;
				end else begin
					tag_we    = 1'b1;
					mem_valid = 1'b1;
					if (line_valid[req_index] && line_dirty[req_index]) begin
						// old line goes out first
						mem_write     = 1'b1;
						mem_line_addr = {line_tag[req_index], req_index};
						state_nx      = WRITE_BACK;
					end else begin
						state_nx = ALLOCATE;
					end
				end
			end
			WRITE_BACK: begin
				if (mem_ready) begin
					mem_valid = 1'b1;  // now fetch the new line
					state_nx  = ALLOCATE;
				end
			end
			ALLOCATE: begin
				if (mem_ready) begin
					bus.fill_we = 1'b1;
					state_nx    = COMPARE;  // completes there as a hit
				end
			end
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			for (int i = 0; i < LINE_COUNT; i++) begin
				line_valid[i] <= 1'b0;
				line_dirty[i] <= 1'b0;
			end
		end else begin
			state <= state_nx;
			if (tag_we) begin
				line_valid[req_index] <= 1'b1;
				line_dirty[req_index] <= req_write;  // write-allocate
			end else if (dirty_set) begin
				line_dirty[req_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tag_we)
			line_tag[req_index] <= req_tag;
	end

endmodule

//--- verilog/word_bank.sv
`timescale 1ns/1ps

module word_bank import dcache_pkg::*; #(
	parameter int BANK_ID = 0  // word position in the line
) (
	input logic      clk,
	line_bus_if.bank bus
);

	word_t   entry [LINE_COUNT];  // one word per cache line
	word_t   merged;
	logic    sel;

	assign sel    = (bus.word_sel == word_sel_t'(BANK_ID));
	assign merged = (entry[bus.index] & ~bus.wmask) | (bus.cpu_wdata & bus.wmask);

	// async read of the addressed line
	assign bus.bank_words[BANK_ID] = entry[bus.index];

	always_ff @(posedge clk) begin
		if (bus.fill_we)
			entry[bus.index] <= bus.fill_line[BANK_ID];  // own slice of the line
		else if (bus.cpu_we && sel)
			entry[bus.index] <= merged;  // strobed bytes only
	end

endmodule

//--- verilog/line_memory.sv
`timescale 1ns/1ps

module line_memory import dcache_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   mem_valid,
	input  logic                   mem_write,
	input  line_addr_t             mem_line_addr,
	output logic                   mem_ready,
	output word_t [LINE_WORDS-1:0] mem_rline,
	line_bus_if.mem                bus
);

	word_t [LINE_WORDS-1:0] store [MEM_LINES];  // whole lines

	line_addr_t             addr_q;   // latched request
	word_t [LINE_WORDS-1:0] wline_q;
	logic                   write_q;
	logic                   busy;
	logic [LAT_CNT_W-1:0]   cnt;      // cycles left until ready

	assign mem_ready = busy && (cnt == '0);
	assign mem_rline = store[addr_q];  // valid with mem_ready

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy    <= 1'b0;
			write_q <= 1'b0;
			cnt     <= '0;
		end else if (mem_valid) begin
			busy    <= 1'b1;
			write_q <= mem_write;
			cnt     <= LAT_CNT_W'(MEM_LATENCY - 1);
		end else if (busy) begin
			if (cnt == '0)
				busy <= 1'b0;  // ready pulse done
			else
				cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_valid) begin
			addr_q <= mem_line_addr;
			if (mem_write) begin
				for (int i = 0; i < LINE_WORDS; i++)
					wline_q[i] <= bus.bank_words[i];  // old line from the banks
			end
		end
	end

	// store starts out zeroed, written when the count ends
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < MEM_LINES; i++)
				store[i] <= '0;
		end else if (mem_ready && write_q) begin
			store[addr_q] <= wline_q;
		end
	end

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       awvalid,
	output logic       awready,
	input  addr_t      awaddr,
	input  logic       wvalid,
	output logic       wready,
	input  word_t      wdata,
	input  strb_t      wstrb,
	output logic       bvalid,
	input  logic       bready,
	output logic [1:0] bresp,
	input  logic       arvalid,
	output logic       arready,
	input  addr_t      araddr,
	output logic       rvalid,
	input  logic       rready,
	output word_t      rdata,
	output logic [1:0] rresp
);

	// port to controller
	logic  req_valid;
	logic  req_write;
	addr_t req_addr;
	word_t req_wdata;
	word_t req_wmask;
	logic  req_done;
	word_t req_rdata;

	// controller to line memory
	logic                   mem_valid;
	logic                   mem_write;
	line_addr_t             mem_line_addr;
	logic                   mem_ready;
	word_t [LINE_WORDS-1:0] mem_rline;

	line_bus_if bus ();

	axil_cpu_port u_port (
		.clk, .rst,
		.awvalid, .awready, .awaddr,
		.wvalid, .wready, .wdata, .wstrb,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr,
		.rvalid, .rready, .rdata, .rresp,
		.req_valid, .req_write, .req_addr, .req_wdata, .req_wmask,
		.req_done, .req_rdata
	);

	dcache_ctrl u_ctrl (
		.clk, .rst,
		.req_valid, .req_write, .req_addr, .req_wdata, .req_wmask,
		.req_done, .req_rdata,
		.mem_valid, .mem_write, .mem_line_addr, .mem_ready, .mem_rline,
		.bus(bus)
	);

	for (genvar b = 0; b < LINE_WORDS; b++) begin : g_bank
		word_bank #(.BANK_ID(b)) u_bank (
			.clk,
			.bus(bus)
		);
	end

	line_memory u_mem (
		.clk, .rst,
		.mem_valid, .mem_write, .mem_line_addr, .mem_ready, .mem_rline,
		.bus(bus)
	);

endmodule

//--- test/dcache_assert.sv
`timescale 1ns/1ps

module dcache_assert import dcache_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       bvalid,
	input logic       bready,
	input logic [1:0] bresp,
	input logic       rvalid,
	input logic       rready,
	input word_t      rdata,
	input logic [1:0] rresp
);

	// read response held with its data until the master takes it
	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid or rdata changed while rready was low");

	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped while bready was low");

	// no error responses in this design
	a_resp_okay: assert property (@(posedge clk) disable iff (rst)
		bresp == RESP_OKAY && rresp == RESP_OKAY)
		else $error("response code other than OKAY");

endmodule

bind dcache_top dcache_assert u_assert (
	.clk(clk), .rst(rst),
	.bvalid(bvalid), .bready(bready), .bresp(bresp),
	.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
);

//--- test/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*;;

	localparam int CLK_PERIOD    = 100;
	localparam int RAND_OPS      = 200;
	localparam int ORDER_OPS     = 60;
	localparam int CYCLES_PER_OP = 2 * MEM_LATENCY + 10;  // watchdog allowance

	logic clk, rst;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	addr_t awaddr, araddr;
	word_t wdata, rdata;
	strb_t wstrb;
	logic [1:0] bresp, rresp;

	integer seed = 22767;
	logic   rand_ready = 1'b0;  // random low periods on bready/rready

	logic [7:0] shadow [1 << ADDR_W];  // byte image of the address space

	// completed reads waiting for the compare process
	word_t exp_q [$];
	word_t got_q [$];
	string name_q [$];
	word_t exp_word, got_word;
	string read_name;

	string cur_test;
	logic  test_active = 1'b0;
	int    cycles_left = 0;
	int    mismatches = 0;
	int    reads_checked = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    errs_at_start;

	dcache_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// expected word built from little endian lanes at the word base
	function automatic word_t ref_read(input addr_t a);
		word_t w;
		addr_t base;
		base = a & ~addr_t'(STRB_W - 1);
		for (int i = 0; i < STRB_W; i++)
			w[8*i +: 8] = shadow[base + addr_t'(i)];
		return w;
	endfunction

	task automatic shadow_write(input addr_t a, input word_t d, input strb_t s);
		addr_t base;
		base = a & ~addr_t'(STRB_W - 1);
		for (int i = 0; i < STRB_W; i++)
			if (s[i]) shadow[base + addr_t'(i)] = d[8*i +: 8];  // strobed bytes only
	endtask

	function automatic logic pick_ready();
		return rand_ready ? 1'($random(seed)) : 1'b1;
	endfunction

	task automatic axi_write(input addr_t a, input word_t d, input strb_t s);
		@(negedge clk);
		awvalid = 1'b1;
		wvalid  = 1'b1;
		awaddr  = a;
		wdata   = d;
		wstrb   = s;
		#1;
		while (!(awready && wready)) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);  // aw and w taken on the rising edge
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = pick_ready();
		#1;
		while (!(bvalid && bready)) begin
			@(negedge clk);
			bready = pick_ready();
			#1;
		end
		@(negedge clk);
		bready = 1'b0;
		shadow_write(a, d, s);
	endtask

	task automatic axi_read(input addr_t a);
		word_t exp;
		exp = ref_read(a);  // shadow is current since only one transaction runs at a time
		@(negedge clk);
		arvalid = 1'b1;
		araddr  = a;
		#1;
		while (!arready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		arvalid = 1'b0;
		rready  = pick_ready();
		#1;
		while (!(rvalid && rready)) begin
			@(negedge clk);
			rready = pick_ready();
			#1;
		end
		exp_q.push_back(exp);
		got_q.push_back(rdata);  // stable until the rising edge
		name_q.push_back(cur_test);
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic random_op(input addr_t mask);
		addr_t a;
		word_t d;
		strb_t s;
		logic  wr;
		a  = addr_t'($random(seed)) & mask;
		wr = 1'($random(seed));
		d  = $random(seed);
		s  = strb_t'($random(seed));
		if (wr)
			axi_write(a, d, s);
		else
			axi_read(a);
	endtask

	task automatic start_test(input string name, input int ops);
		cur_test      = name;
		errs_at_start = mismatches;
		cycles_left   = ops * CYCLES_PER_OP;
		test_active   = 1'b1;
	endtask

	task automatic end_test();
		test_active = 1'b0;
		tests_run++;
		if (mismatches != errs_at_start) begin
			tests_failed++;
			$display("test %s: FAIL, %0d mismatches", cur_test, mismatches - errs_at_start);
		end else begin
			$display("test %s: ok", cur_test);
		end
	endtask

	// compare process checks reads pushed before this edge
	always @(posedge clk) begin
		while (got_q.size() > 0) begin
			exp_word  = exp_q.pop_front();
			got_word  = got_q.pop_front();
			read_name = name_q.pop_front();
			reads_checked++;
			assert (got_word === exp_word) else begin
				$display("MISMATCH %s: expected %08h, actual %08h", read_name, exp_word,
					got_word);
				mismatches++;
			end
		end
	end

	// watchdog with a cycle budget per test
	always @(posedge clk) begin
		if (test_active) begin
			if (cycles_left == 0) begin
				$display("timeout: test %s did not finish in its cycle budget", cur_test);
				$display("Test failed");
				$finish;
			end else begin
				cycles_left--;
			end
		end
	end

	initial begin
		awvalid = 1'b0;
		wvalid  = 1'b0;
		arvalid = 1'b0;
		bready  = 1'b0;
		rready  = 1'b0;
		awaddr  = '0;
		araddr  = '0;
		wdata   = '0;
		wstrb   = '0;
		rst     = 1'b1;
		for (int i = 0; i < (1 << ADDR_W); i++)
			shadow[i] = 8'h00;  // backing store starts zeroed
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		start_test("reset_zero", 4);
		axi_read(12'h000);
		axi_read(12'h104);
		axi_read(12'h7f8);
		axi_read(12'hffc);
		end_test();

		start_test("full_word", 2);
		axi_write(12'h020, 32'hdeadbeef, 4'hf);
		axi_read(12'h020);
		end_test();

		start_test("byte_strobes", 7);
		axi_write(12'h0a4, 32'h11223344, 4'hf);
		axi_write(12'h0a4, 32'haabbccdd, 4'b0001);
		axi_read(12'h0a4);
		axi_write(12'h0a4, 32'h55667788, 4'b0110);
		axi_read(12'h0a4);
		axi_write(12'h0a6, 32'h99000000, 4'b1000);  // unaligned address still picks lanes by strobe
		axi_read(12'h0a4);
		end_test();

		// 0x340 and 0x540 share index 4 with tags 3 and 5
		start_test("dirty_evict", 11);
		for (int i = 0; i < LINE_WORDS; i++)
			axi_write(addr_t'(12'h340 + 4 * i), 32'hc0de0000 | i, 4'hf);
		axi_read(12'h540);  // write-back of the dirty line
		axi_write(12'h548, 32'h0badf00d, 4'hf);
		for (int i = 0; i < LINE_WORDS; i++)
			axi_read(addr_t'(12'h340 + 4 * i));  // refill from the store
		axi_read(12'h548);
		end_test();

		start_test("random_mix", RAND_OPS);
		repeat (RAND_OPS) random_op(12'hfff);
		end_test();

		rand_ready = 1'b1;
		start_test("ready_stall", ORDER_OPS);
		repeat (ORDER_OPS) random_op(12'h1ff);  // two tags per index give many evictions
		end_test();

		$display("%0d tests, %0d with errors, %0d reads checked, %0d mismatches",
			tests_run, tests_failed, reads_checked, mismatches);
		if (tests_failed == 0 && mismatches == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- project.f
verilog/dcache_pkg.sv
verilog/line_bus_if.sv
verilog/axil_cpu_port.sv
verilog/dcache_ctrl.sv
verilog/word_bank.sv
verilog/line_memory.sv
verilog/dcache_top.sv
test/dcache_assert.sv
test/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
	-f project.f --Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
	echo "verilator build did not succeed"
	exit 1
fi

./obj_dir/dcache_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$log"; then
	exit 1
fi
exit 0
